// File: hdl/dbus_pkg.sv
package dbus_pkg;

  localparam int N_UNITS = 2;
  localparam int UNIT_W = (N_UNITS > 1) ? $clog2(N_UNITS) : 1;

  // Databus geometry
  localparam int ADDR_W = 8;         // 256-word memory
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int LEN_W = 4;          // Beats minus one

  // CPU address is {unit, offset}
  localparam int CPU_ADDR_W = UNIT_W + 3;

  localparam logic [2:0] REG_ADDR = 3'd0;
  localparam logic [2:0] REG_LEN = 3'd1;
  localparam logic [2:0] REG_SEED = 3'd2;
  localparam logic [2:0] REG_CTRL = 3'd3;  // Wr: bit0 start, bit1 write. Rd: bit0 busy, bit1 done
  localparam logic [2:0] REG_SUM = 3'd4;

endpackage

// File: hdl/unit_regs.sv
`timescale 1ns/1ns

module unit_regs (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           cpu_valid,
  input  logic [dbus_pkg::STRB_W-1:0]                    cpu_wstrb,
  input  logic [dbus_pkg::CPU_ADDR_W-1:0]                cpu_addr,
  input  logic [dbus_pkg::DATA_W-1:0]                    cpu_wdata,
  output logic [dbus_pkg::DATA_W-1:0]                    cpu_rdata,
  output logic                                           cpu_ready,
  output logic [dbus_pkg::N_UNITS*dbus_pkg::ADDR_W-1:0]  cfg_addr,
  output logic [dbus_pkg::N_UNITS*dbus_pkg::LEN_W-1:0]   cfg_len,
  output logic [dbus_pkg::N_UNITS*dbus_pkg::DATA_W-1:0]  cfg_seed,
  output logic [dbus_pkg::N_UNITS-1:0]                   cfg_write,
  output logic [dbus_pkg::N_UNITS-1:0]                   start,
  input  logic [dbus_pkg::N_UNITS-1:0]                   busy,
  input  logic [dbus_pkg::N_UNITS*dbus_pkg::DATA_W-1:0]  sum
);

  logic [dbus_pkg::UNIT_W-1:0] unit_sel;
  logic [2:0]                  reg_off;
  logic                        accept;
  logic                        is_write;
  logic [dbus_pkg::N_UNITS-1:0] busy_q;
  logic [dbus_pkg::N_UNITS-1:0] done;
  logic [dbus_pkg::DATA_W-1:0]  rd_mux;

  assign unit_sel = cpu_addr[dbus_pkg::CPU_ADDR_W-1:3];
  assign reg_off = cpu_addr[2:0];
  assign accept = cpu_valid && !cpu_ready;  // Request still held during its ready cycle
  assign is_write = |cpu_wstrb;

  always_ff @(posedge clk) begin
    if (accept && is_write) begin
      case (reg_off)
        dbus_pkg::REG_ADDR:
          cfg_addr[unit_sel*dbus_pkg::ADDR_W +: dbus_pkg::ADDR_W] <=
              cpu_wdata[dbus_pkg::ADDR_W-1:0];
        dbus_pkg::REG_LEN:
          cfg_len[unit_sel*dbus_pkg::LEN_W +: dbus_pkg::LEN_W] <=
              cpu_wdata[dbus_pkg::LEN_W-1:0];
        dbus_pkg::REG_SEED:
          cfg_seed[unit_sel*dbus_pkg::DATA_W +: dbus_pkg::DATA_W] <= cpu_wdata;
        dbus_pkg::REG_CTRL:
          cfg_write[unit_sel] <= cpu_wdata[1];
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_mux = '0;
    case (reg_off)
      dbus_pkg::REG_ADDR:
        rd_mux[dbus_pkg::ADDR_W-1:0] = cfg_addr[unit_sel*dbus_pkg::ADDR_W +: dbus_pkg::ADDR_W];
      dbus_pkg::REG_LEN:
        rd_mux[dbus_pkg::LEN_W-1:0] = cfg_len[unit_sel*dbus_pkg::LEN_W +: dbus_pkg::LEN_W];
      dbus_pkg::REG_SEED:
        rd_mux = cfg_seed[unit_sel*dbus_pkg::DATA_W +: dbus_pkg::DATA_W];
      dbus_pkg::REG_CTRL:
        rd_mux[1:0] = {done[unit_sel], busy[unit_sel]};
      dbus_pkg::REG_SUM:
        rd_mux = sum[unit_sel*dbus_pkg::DATA_W +: dbus_pkg::DATA_W];
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cpu_ready <= 1'b0;
      cpu_rdata <= '0;
      start <= '0;
      busy_q <= '0;
      done <= '0;
    end else begin
      cpu_ready <= accept;
      cpu_rdata <= (accept && !is_write) ? rd_mux : '0;
      busy_q <= busy;
      start <= '0;  // Single-cycle pulse
      if (accept && is_write && reg_off == dbus_pkg::REG_CTRL) begin
        start[unit_sel] <= cpu_wdata[0];
      end
      for (int i = 0; i < dbus_pkg::N_UNITS; i++) begin
        if (start[i]) begin
          done[i] <= 1'b0;
        end else if (busy_q[i] && !busy[i]) begin
          done[i] <= 1'b1;  // Burst just finished
        end
      end
    end
  end

  // A unit mid-burst never receives a second start
  a_start_idle: assert property (@(posedge clk) disable iff (rst) (start & busy) == '0);

endmodule

// File: hdl/xfer_unit.sv
`timescale 1ns/1ns

module xfer_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  input  logic [dbus_pkg::ADDR_W-1:0] cfg_addr,
  input  logic [dbus_pkg::LEN_W-1:0]  cfg_len,
  input  logic [dbus_pkg::DATA_W-1:0] cfg_seed,
  input  logic                        cfg_write,
  output logic                        busy,
  output logic [dbus_pkg::DATA_W-1:0] sum,
  output logic                        d_valid,
  input  logic                        d_ready,
  input  logic                        d_last,
  output logic [dbus_pkg::ADDR_W-1:0] d_addr,
  input  logic [dbus_pkg::DATA_W-1:0] d_rdata,
  output logic [dbus_pkg::DATA_W-1:0] d_wdata,
  output logic [dbus_pkg::STRB_W-1:0] d_wstrb,
  output logic [dbus_pkg::LEN_W-1:0]  d_len
);

  logic [dbus_pkg::ADDR_W-1:0] addr_q;
  logic [dbus_pkg::LEN_W-1:0]  len_q;
  logic [dbus_pkg::DATA_W-1:0] seed_q;
  logic                        write_q;
  logic [dbus_pkg::LEN_W-1:0]  beat;
  logic                        xfer;

  assign xfer = d_valid && d_ready;

  // Burst request stays stable while busy
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= cfg_addr;
      len_q <= cfg_len;
      seed_q <= cfg_seed;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy <= 1'b0;
      write_q <= 1'b0;
      beat <= '0;
      sum <= '0;
    end else if (start) begin
      busy <= 1'b1;
      write_q <= cfg_write;
      beat <= '0;
      if (!cfg_write) begin
        sum <= '0;
      end
    end else if (xfer) begin
      beat <= beat + 1'b1;
      if (!write_q) begin
        sum <= sum + d_rdata;  // Running checksum of read data
      end
      if (d_last) begin
        busy <= 1'b0;
      end
    end
  end

  assign d_valid = busy;
  assign d_addr = addr_q;  // Memory steps from this base through the burst
  assign d_len = len_q;
  assign d_wdata = seed_q + {{(dbus_pkg::DATA_W-dbus_pkg::LEN_W){1'b0}}, beat};
  assign d_wstrb = write_q ? '1 : '0;

  // Burst only ends on the unit's own final beat
  a_last_beat: assert property (@(posedge clk) disable iff (rst)
    d_valid && d_ready && d_last |-> beat == len_q);

endmodule

// File: hdl/dbus_merge.sv
`timescale 1ns/1ns

module dbus_merge (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic [dbus_pkg::N_UNITS-1:0]                   d_valid,
  output logic [dbus_pkg::N_UNITS-1:0]                   d_ready,
  output logic [dbus_pkg::N_UNITS-1:0]                   d_last,
  input  logic [dbus_pkg::N_UNITS*dbus_pkg::ADDR_W-1:0]  d_addr,
  input  logic [dbus_pkg::N_UNITS*dbus_pkg::DATA_W-1:0]  d_wdata,
  input  logic [dbus_pkg::N_UNITS*dbus_pkg::STRB_W-1:0]  d_wstrb,
  input  logic [dbus_pkg::N_UNITS*dbus_pkg::LEN_W-1:0]   d_len,
  output logic [dbus_pkg::DATA_W-1:0]                    d_rdata,
  output logic                                           w_valid,
  input  logic                                           w_ready,
  output logic [dbus_pkg::ADDR_W-1:0]                    w_addr,
  output logic [dbus_pkg::DATA_W-1:0]                    w_data,
  output logic [dbus_pkg::STRB_W-1:0]                    w_strb,
  output logic [dbus_pkg::LEN_W-1:0]                     w_len,
  input  logic                                           w_last,
  output logic                                           r_valid,
  input  logic                                           r_ready,
  output logic [dbus_pkg::ADDR_W-1:0]                    r_addr,
  input  logic [dbus_pkg::DATA_W-1:0]                    r_data,
  output logic [dbus_pkg::LEN_W-1:0]                     r_len,
  input  logic                                           r_last
);

  logic                        w_running;
  logic                        r_running;
  logic [dbus_pkg::UNIT_W-1:0] w_sel;
  logic [dbus_pkg::UNIT_W-1:0] r_sel;
  logic                        w_req_valid;
  logic                        r_req_valid;
  logic [dbus_pkg::UNIT_W-1:0] w_req;
  logic [dbus_pkg::UNIT_W-1:0] r_req;

  // Non-zero strobe marks a write; last match wins so higher index has priority
  always_comb begin
    w_req_valid = 1'b0;
    r_req_valid = 1'b0;
    w_req = '0;
    r_req = '0;
    for (int i = 0; i < dbus_pkg::N_UNITS; i++) begin
      if (d_valid[i]) begin
        if (|d_wstrb[i*dbus_pkg::STRB_W +: dbus_pkg::STRB_W]) begin
          w_req_valid = 1'b1;
          w_req = i[dbus_pkg::UNIT_W-1:0];
        end else begin
          r_req_valid = 1'b1;
          r_req = i[dbus_pkg::UNIT_W-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_running <= 1'b0;
      r_running <= 1'b0;
      w_sel <= '0;
      r_sel <= '0;
    end else begin
      if (!w_running && w_req_valid) begin
        w_running <= 1'b1;
        w_sel <= w_req;
      end else if (w_valid && w_ready && w_last) begin
        w_running <= 1'b0;
      end
      if (!r_running && r_req_valid) begin
        r_running <= 1'b1;
        r_sel <= r_req;
      end else if (r_valid && r_ready && r_last) begin
        r_running <= 1'b0;
      end
    end
  end

  always_comb begin
    w_valid = 1'b0;
    w_addr = '0;
    w_data = '0;
    w_strb = '0;
    w_len = '0;
    r_valid = 1'b0;
    r_addr = '0;
    r_len = '0;
    if (w_running) begin
      w_valid = d_valid[w_sel];
      w_addr = d_addr[w_sel*dbus_pkg::ADDR_W +: dbus_pkg::ADDR_W];
      w_data = d_wdata[w_sel*dbus_pkg::DATA_W +: dbus_pkg::DATA_W];
      w_strb = d_wstrb[w_sel*dbus_pkg::STRB_W +: dbus_pkg::STRB_W];
      w_len = d_len[w_sel*dbus_pkg::LEN_W +: dbus_pkg::LEN_W];
    end
    if (r_running) begin
      r_valid = d_valid[r_sel];
      r_addr = d_addr[r_sel*dbus_pkg::ADDR_W +: dbus_pkg::ADDR_W];
      r_len = d_len[r_sel*dbus_pkg::LEN_W +: dbus_pkg::LEN_W];
    end
  end

  // Handshake goes back to the granted unit only
  always_comb begin
    for (int i = 0; i < dbus_pkg::N_UNITS; i++) begin
      d_ready[i] = (w_running && w_sel == i[dbus_pkg::UNIT_W-1:0] && w_ready) ||
                   (r_running && r_sel == i[dbus_pkg::UNIT_W-1:0] && r_ready);
      d_last[i] = (w_running && w_sel == i[dbus_pkg::UNIT_W-1:0] && w_last) ||
                  (r_running && r_sel == i[dbus_pkg::UNIT_W-1:0] && r_last);
    end
  end

  assign d_rdata = r_data;

  a_split_grant: assert property (@(posedge clk) disable iff (rst)
    (w_running && r_running) |-> (w_sel != r_sel));

endmodule

// File: hdl/burst_mem.sv
`timescale 1ns/1ns

module burst_mem (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        mem_stall,
  input  logic                        w_valid,
  output logic                        w_ready,
  input  logic [dbus_pkg::ADDR_W-1:0] w_addr,
  input  logic [dbus_pkg::DATA_W-1:0] w_data,
  input  logic [dbus_pkg::STRB_W-1:0] w_strb,
  input  logic [dbus_pkg::LEN_W-1:0]  w_len,
  output logic                        w_last,
  input  logic                        r_valid,
  output logic                        r_ready,
  input  logic [dbus_pkg::ADDR_W-1:0] r_addr,
  output logic [dbus_pkg::DATA_W-1:0] r_data,
  input  logic [dbus_pkg::LEN_W-1:0]  r_len,
  output logic                        r_last
);

  logic [dbus_pkg::DATA_W-1:0] mem [0:(1 << dbus_pkg::ADDR_W)-1];
  logic [dbus_pkg::LEN_W-1:0]  w_cnt;
  logic [dbus_pkg::LEN_W-1:0]  r_cnt;
  logic [dbus_pkg::ADDR_W-1:0] w_idx;
  logic [dbus_pkg::ADDR_W-1:0] r_idx;

  assign w_ready = !mem_stall;
  assign r_ready = !mem_stall;

  assign w_idx = w_addr + {{(dbus_pkg::ADDR_W-dbus_pkg::LEN_W){1'b0}}, w_cnt};
  assign r_idx = r_addr + {{(dbus_pkg::ADDR_W-dbus_pkg::LEN_W){1'b0}}, r_cnt};
  assign w_last = (w_cnt == w_len);
  assign r_last = (r_cnt == r_len);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_cnt <= '0;
      r_cnt <= '0;
    end else begin
      if (w_valid && w_ready) begin
        w_cnt <= w_last ? '0 : w_cnt + 1'b1;
      end
      if (r_valid && r_ready) begin
        r_cnt <= r_last ? '0 : r_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (w_valid && w_ready) begin
      for (int b = 0; b < dbus_pkg::STRB_W; b++) begin
        if (w_strb[b]) begin
          mem[w_idx][b*8 +: 8] <= w_data[b*8 +: 8];  // Byte lane write
        end
      end
    end
  end

  assign r_data = mem[r_idx];

endmodule

// File: hdl/dma_top.sv
`timescale 1ns/1ns

module dma_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            mem_stall,
  input  logic                            cpu_valid,
  input  logic [dbus_pkg::STRB_W-1:0]     cpu_wstrb,
  input  logic [dbus_pkg::CPU_ADDR_W-1:0] cpu_addr,
  input  logic [dbus_pkg::DATA_W-1:0]     cpu_wdata,
  output logic [dbus_pkg::DATA_W-1:0]     cpu_rdata,
  output logic                            cpu_ready
);

  // Register block to units
  logic [dbus_pkg::N_UNITS*dbus_pkg::ADDR_W-1:0] cfg_addr;
  logic [dbus_pkg::N_UNITS*dbus_pkg::LEN_W-1:0]  cfg_len;
  logic [dbus_pkg::N_UNITS*dbus_pkg::DATA_W-1:0] cfg_seed;
  logic [dbus_pkg::N_UNITS-1:0]                  cfg_write;
  logic [dbus_pkg::N_UNITS-1:0]                  start;
  logic [dbus_pkg::N_UNITS-1:0]                  busy;
  logic [dbus_pkg::N_UNITS*dbus_pkg::DATA_W-1:0] sum;

  // Unit databus slices
  logic [dbus_pkg::N_UNITS-1:0]                  d_valid;
  logic [dbus_pkg::N_UNITS-1:0]                  d_ready;
  logic [dbus_pkg::N_UNITS-1:0]                  d_last;
  logic [dbus_pkg::N_UNITS*dbus_pkg::ADDR_W-1:0] d_addr;
  logic [dbus_pkg::N_UNITS*dbus_pkg::DATA_W-1:0] d_wdata;
  logic [dbus_pkg::N_UNITS*dbus_pkg::STRB_W-1:0] d_wstrb;
  logic [dbus_pkg::N_UNITS*dbus_pkg::LEN_W-1:0]  d_len;
  logic [dbus_pkg::DATA_W-1:0]                   d_rdata;

  logic                        w_valid;
  logic                        w_ready;
  logic [dbus_pkg::ADDR_W-1:0] w_addr;
  logic [dbus_pkg::DATA_W-1:0] w_data;
  logic [dbus_pkg::STRB_W-1:0] w_strb;
  logic [dbus_pkg::LEN_W-1:0]  w_len;
  logic                        w_last;
  logic                        r_valid;
  logic                        r_ready;
  logic [dbus_pkg::ADDR_W-1:0] r_addr;
  logic [dbus_pkg::DATA_W-1:0] r_data;
  logic [dbus_pkg::LEN_W-1:0]  r_len;
  logic                        r_last;

  unit_regs regs_i (.*);

  for (genvar g = 0; g < dbus_pkg::N_UNITS; g++) begin : g_unit
    xfer_unit unit_i (
      .clk(clk),
      .rst(rst),
      .start(start[g]),
      .cfg_addr(cfg_addr[g*dbus_pkg::ADDR_W +: dbus_pkg::ADDR_W]),
      .cfg_len(cfg_len[g*dbus_pkg::LEN_W +: dbus_pkg::LEN_W]),
      .cfg_seed(cfg_seed[g*dbus_pkg::DATA_W +: dbus_pkg::DATA_W]),
      .cfg_write(cfg_write[g]),
      .busy(busy[g]),
      .sum(sum[g*dbus_pkg::DATA_W +: dbus_pkg::DATA_W]),
      .d_valid(d_valid[g]),
      .d_ready(d_ready[g]),
      .d_last(d_last[g]),
      .d_addr(d_addr[g*dbus_pkg::ADDR_W +: dbus_pkg::ADDR_W]),
      .d_rdata(d_rdata),  // Shared read data
      .d_wdata(d_wdata[g*dbus_pkg::DATA_W +: dbus_pkg::DATA_W]),
      .d_wstrb(d_wstrb[g*dbus_pkg::STRB_W +: dbus_pkg::STRB_W]),
      .d_len(d_len[g*dbus_pkg::LEN_W +: dbus_pkg::LEN_W])
    );
  end

  dbus_merge merge_i (.*);

  burst_mem mem_i (.*);

endmodule

// File: test/tb_dma.sv
`timescale 1ns/1ns

module tb_dma;

  localparam int MAX_LINES = 128;

  logic                            clk = 1'b0;
  logic                            rst;
  logic                            mem_stall = 1'b0;
  logic                            cpu_valid;
  logic [dbus_pkg::STRB_W-1:0]     cpu_wstrb;
  logic [dbus_pkg::CPU_ADDR_W-1:0] cpu_addr;
  logic [dbus_pkg::DATA_W-1:0]     cpu_wdata;
  logic [dbus_pkg::DATA_W-1:0]     cpu_rdata;
  logic                            cpu_ready;

  // Trace table, one entry per line
  logic [8*8-1:0] t_name [MAX_LINES];
  logic [8*8-1:0] t_op [MAX_LINES];
  logic [31:0]    t_unit [MAX_LINES];
  logic [31:0]    t_addr [MAX_LINES];
  logic [31:0]    t_val [MAX_LINES];
  logic [31:0]    t_exp [MAX_LINES];
  int             n_lines;
  int             n_beats;
  logic           loaded = 1'b0;
  logic [1:0]     stall_mode;  // 0 off, 1 random, 2 held
  logic [31:0]    lfsr_state = 32'h4f74;

  dma_top dma_top_i (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
  endfunction

  always @(posedge clk) begin
    logic [31:0] nxt;
    nxt = lfsr_step(lfsr_state);
    if (stall_mode == 2'd1) begin
      lfsr_state <= nxt;
      mem_stall <= nxt[0];
    end else begin
      mem_stall <= (stall_mode == 2'd2);
    end
  end

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input logic [8*8-1:0] name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act == exp) else begin
      $display("FAIL %0s: expected %h, actual %h", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic cpu_access(input logic [dbus_pkg::UNIT_W-1:0] unit, input logic [2:0] off,
                            input logic write, input logic [31:0] data,
                            output logic [31:0] rdata);
    int waits;
    @(posedge clk);
    cpu_valid <= 1'b1;
    cpu_wstrb <= write ? '1 : '0;
    cpu_addr <= {unit, off};
    cpu_wdata <= data;
    waits = 0;
    do begin
      @(negedge clk);
      waits++;
    end while (!cpu_ready);
    assert (waits == 2) else abort_run("cpu_ready did not follow cpu_valid by one cycle");
    rdata = cpu_rdata;
    @(posedge clk);
    cpu_valid <= 1'b0;
    cpu_wstrb <= '0;
  endtask

  task automatic load_trace();
    int             fd;
    int             code;
    int             len_seen [dbus_pkg::N_UNITS];
    logic [8*8-1:0] tok;
    logic [8*96-1:0] rest;
    fd = $fopen("test/dma_trace.txt", "r");
    if (fd == 0) abort_run("cannot open test/dma_trace.txt");
    n_lines = 0;
    n_beats = 0;
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        code = $fgets(rest, fd);  // Column notes
      end else begin
        code = $fscanf(fd, "%s %h %h %h %h", t_op[n_lines], t_unit[n_lines],
                       t_addr[n_lines], t_val[n_lines], t_exp[n_lines]);
        if (code != 5) abort_run("malformed line in trace file");
        t_name[n_lines] = tok;
        if (t_op[n_lines] == "wr") begin
          len_seen[t_unit[n_lines]] = int'(t_exp[n_lines] & 32'h0000000f);
        end
        if (t_op[n_lines] == "go") begin
          n_beats += len_seen[t_unit[n_lines]] + 1;
        end
        n_lines++;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_line(input int i, input int pass);
    logic [31:0]                 rd;
    logic [dbus_pkg::UNIT_W-1:0] u;
    u = t_unit[i][dbus_pkg::UNIT_W-1:0];
    case (t_op[i])
      "wr": begin  // Configure, then read each field back
        cpu_access(u, dbus_pkg::REG_ADDR, 1'b1, t_addr[i], rd);
        cpu_access(u, dbus_pkg::REG_LEN, 1'b1, t_exp[i], rd);
        cpu_access(u, dbus_pkg::REG_SEED, 1'b1, t_val[i], rd);
        cpu_access(u, dbus_pkg::REG_ADDR, 1'b0, 32'd0, rd);
        check_value(t_name[i], t_addr[i] & ((32'd1 << dbus_pkg::ADDR_W) - 32'd1), rd);
        cpu_access(u, dbus_pkg::REG_LEN, 1'b0, 32'd0, rd);
        check_value(t_name[i], t_exp[i] & ((32'd1 << dbus_pkg::LEN_W) - 32'd1), rd);
        cpu_access(u, dbus_pkg::REG_SEED, 1'b0, 32'd0, rd);
        check_value(t_name[i], t_val[i], rd);
      end
      "go": cpu_access(u, dbus_pkg::REG_CTRL, 1'b1, {30'd0, t_val[i][0], 1'b1}, rd);
      "wait": begin
        do begin
          cpu_access(u, dbus_pkg::REG_CTRL, 1'b0, 32'd0, rd);
        end while (!rd[1]);
      end
      "rd": begin
        cpu_access(u, t_addr[i][2:0], 1'b0, 32'd0, rd);
        check_value(t_name[i], t_exp[i], rd);
      end
      "chk": begin
        cpu_access(u, dbus_pkg::REG_SUM, 1'b0, 32'd0, rd);
        check_value(t_name[i], t_exp[i], rd);
      end
      "stall": begin
        @(posedge clk);
        stall_mode <= (pass == 0 && t_val[i] == 32'd1) ? 2'd0 : t_val[i][1:0];  // Random only on replay
      end
      default: abort_run("unknown op in trace file");
    endcase
  endtask

  initial begin
    int budget;
    wait (loaded);
    budget = 2 * (n_beats * 64 + n_lines * 200) + 16;  // Two passes plus reset
    #(budget * 4);
    $display("ERROR: timeout, trace not finished after %0d cycles", budget);
    $display("FAIL: see errors above");
    $fatal(1);
  end

  initial begin
    rst = 1'b1;
    cpu_valid = 1'b0;
    cpu_wstrb = '0;
    cpu_addr = '0;
    cpu_wdata = '0;
    stall_mode = 2'd0;
    load_trace();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < n_lines; i++) begin
        run_line(i, pass);
      end
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: test/dma_trace.txt
# name op unit addr value expect (hex)
# wr: addr seed len | go: value 1 write 0 read | rd: addr is offset | stall: value is mode
t1 wr 0 1ff 12345678 1f
t1 wr 1 2a5 87654321 13
t2 stall 0 0 1 0
t2 wr 0 10 64 7
t2 go 0 0 1 0
t2 wait 0 0 0 0
t2 go 0 0 0 0
t2 wait 0 0 0 0
t2 chk 0 0 0 33c
t3 wr 0 20 3e8 3
t3 wr 1 30 7d0 5
t3 go 0 0 1 0
t3 go 1 0 1 0
t3 wait 0 0 0 0
t3 wait 1 0 0 0
t3 go 0 0 0 0
t3 go 1 0 0 0
t3 wait 0 0 0 0
t3 wait 1 0 0 0
t3 chk 0 0 0 fa6
t3 chk 1 0 0 2eef
t4 wr 0 10 0 7
t4 wr 1 40 fffffff8 f
t4 go 1 0 1 0
t4 go 0 0 0 0
t4 wait 0 0 0 0
t4 wait 1 0 0 0
t4 rd 0 3 0 2
t4 rd 1 3 0 2
t4 chk 0 0 0 33c
t4 go 1 0 0 0
t4 wait 1 0 0 0
t4 chk 1 0 0 fffffff8
t6 stall 0 0 2 0
t6 wr 0 80 0 f
t6 go 0 0 1 0
t6 rd 0 3 0 1
t6 stall 0 0 0 0
t6 wait 0 0 0 0
t6 rd 0 3 0 2
t6 stall 0 0 2 0
t6 go 0 0 0 0
t6 rd 0 3 0 1
t6 stall 0 0 0 0
t6 wait 0 0 0 0
t6 chk 0 0 0 78

// File: list.f
hdl/dbus_pkg.sv
hdl/unit_regs.sv
hdl/xfer_unit.sv
hdl/dbus_merge.sv
hdl/burst_mem.sv
hdl/dma_top.sv
test/tb_dma.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dma -f list.f -o sim_dma \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_dma > sim.log 2>&1 || echo "FAIL: see errors above" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
